/* ciPkg.sv */
package ciPkg;

  localparam int CiDataBits = 32;
  localparam int CiIdBits = 8;

  typedef logic [CiDataBits-1:0] ciDataT;
  typedef logic [CiIdBits-1:0] ciIdT;

  typedef struct packed {
    logic   start;
    ciIdT   id;
    ciDataT dataA;
    ciDataT dataB;
  } ciRequestT;

  typedef struct packed {
    logic   done;
    ciDataT result;
  } ciUnitResponseT;

  typedef struct packed {
    logic   done;
    logic   error;
    ciDataT result;
  } ciResponseT;

  localparam ciIdT SwapByteId = 8'd1;
  localparam ciIdT GrayscaleId = 8'hD;

  // Cycles without a unit answer before the combiner gives up
  localparam int CiTimeoutCycles = 3;

  typedef logic [$clog2(CiTimeoutCycles)-1:0] ciTimeoutT;

  localparam int ResetCountBits = 5; // Top bit set means reset is over

endpackage

/* pixelPkg.sv */
package pixelPkg;

  localparam int RedBits = 5;
  localparam int GreenBits = 6;
  localparam int BlueBits = 5;
  localparam int GrayBits = 8;
  localparam int LumaWeightBits = 8;
  localparam int LumaProductBits = GrayBits + LumaWeightBits;

  typedef struct packed {
    logic [RedBits-1:0]   red;
    logic [GreenBits-1:0] green;
    logic [BlueBits-1:0]  blue;
  } rgb565T;

  typedef logic [GrayBits-1:0] grayT;
  typedef logic [LumaWeightBits-1:0] lumaWeightT;
  typedef logic [LumaProductBits-1:0] lumaProductT;

  // Luminance weights scaled so that they add up to 256
  localparam lumaWeightT RedWeight = 8'd54;
  localparam lumaWeightT GreenWeight = 8'd183;
  localparam lumaWeightT BlueWeight = 8'd19;

endpackage

/* resetCounter.sv */
`timescale 1ns/1ps

module resetCounter import ciPkg::*; (
  input  logic s_systemClock,
  input  logic s_pllLocked,
  output logic ready
);

  logic [ResetCountBits-1:0] resetCount;

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      resetCount <= '0;
    end else if (!resetCount[ResetCountBits-1]) begin
      resetCount <= resetCount + 1'b1; // Stops once the top bit is set
    end
  end

  assign ready = resetCount[ResetCountBits-1];

endmodule

/* byteSwapIse.sv */
`timescale 1ns/1ps

module byteSwapIse import ciPkg::*; (
  input  logic           s_systemClock,
  input  logic           ready,
  input  ciRequestT      request,
  output ciUnitResponseT unitResponse
);

  logic   hit;
  ciDataT swapped;
  ciDataT dataA;

  assign dataA = request.dataA;
  assign hit = request.start && (request.id == SwapByteId);

  always_comb begin
    if (request.dataB[0]) begin
      swapped = {dataA[23:16], dataA[31:24], dataA[7:0], dataA[15:8]}; // Swap within each half
    end else begin
      swapped = {dataA[7:0], dataA[15:8], dataA[23:16], dataA[31:24]}; // Full reversal
    end
  end

  // Both fields stay zero when idle so the combiner can OR the units together
  always_ff @(posedge s_systemClock or negedge ready) begin
    if (!ready) begin
      unitResponse.done <= 1'b0;
      unitResponse.result <= '0;
    end else begin
      unitResponse.done <= hit;
      unitResponse.result <= hit ? swapped : '0;
    end
  end

endmodule

/* grayscaleIse.sv */
`timescale 1ns/1ps

module grayscaleIse import ciPkg::*, pixelPkg::*; (
  input  logic           s_systemClock,
  input  logic           ready,
  input  ciRequestT      request,
  output ciUnitResponseT unitResponse
);

  logic        hit;
  rgb565T      pixel;
  grayT        redExpanded;
  grayT        greenExpanded;
  grayT        blueExpanded;
  logic        stage1Valid;
  lumaProductT redProduct;
  lumaProductT greenProduct;
  lumaProductT blueProduct;
  lumaProductT lumaSum;
  grayT        gray;

  assign hit = request.start && (request.id == GrayscaleId);
  assign pixel = request.dataA[15:0];

  // Each channel is widened by repeating its own top bits below it
  assign redExpanded = {pixel.red, pixel.red[RedBits-1 -: GrayBits-RedBits]};
  assign greenExpanded = {pixel.green, pixel.green[GreenBits-1 -: GrayBits-GreenBits]};
  assign blueExpanded = {pixel.blue, pixel.blue[BlueBits-1 -: GrayBits-BlueBits]};

  always_ff @(posedge s_systemClock or negedge ready) begin
    if (!ready) begin
      stage1Valid <= 1'b0;
    end else begin
      stage1Valid <= hit;
    end
  end

  always_ff @(posedge s_systemClock) begin
    redProduct <= lumaProductT'(redExpanded) * lumaProductT'(RedWeight);
    greenProduct <= lumaProductT'(greenExpanded) * lumaProductT'(GreenWeight);
    blueProduct <= lumaProductT'(blueExpanded) * lumaProductT'(BlueWeight);
  end

  // The weights add up to 256, so the sum cannot overflow and the top byte is the gray value
  assign lumaSum = redProduct + greenProduct + blueProduct;
  assign gray = lumaSum[LumaProductBits-1 -: GrayBits];

  always_ff @(posedge s_systemClock or negedge ready) begin
    if (!ready) begin
      unitResponse.done <= 1'b0;
      unitResponse.result <= '0;
    end else begin
      unitResponse.done <= stage1Valid;
      unitResponse.result <= stage1Valid ? {{(CiDataBits-GrayBits){1'b0}}, gray} : '0;
    end
  end

endmodule

/* ciCombiner.sv */
`timescale 1ns/1ps

module ciCombiner import ciPkg::*; (
  input  logic           s_systemClock,
  input  logic           ready,
  input  logic           start,
  input  ciUnitResponseT swapResponse,
  input  ciUnitResponseT grayResponse,
  output ciResponseT     response
);

  ciUnitResponseT merged;
  logic           pending;
  ciTimeoutT      timeoutCount;
  logic           timeoutHit;
  logic           doneReg;
  logic           errorReg;
  ciDataT         resultReg;

  // Idle units drive zeros, so a plain OR selects the one that answers
  assign merged.done = swapResponse.done | grayResponse.done;
  assign merged.result = swapResponse.result | grayResponse.result;

  assign timeoutHit = pending && (timeoutCount == '0) && !merged.done;

  always_ff @(posedge s_systemClock or negedge ready) begin
    if (!ready) begin
      pending <= 1'b0;
      timeoutCount <= '0;
    end else if (start) begin
      pending <= 1'b1;
      timeoutCount <= ciTimeoutT'(CiTimeoutCycles - 1);
    end else if (merged.done || timeoutHit) begin
      pending <= 1'b0;
    end else if (pending) begin
      timeoutCount <= timeoutCount - 1'b1;
    end
  end

  always_ff @(posedge s_systemClock or negedge ready) begin
    if (!ready) begin
      doneReg <= 1'b0;
      errorReg <= 1'b0;
    end else begin
      doneReg <= merged.done | timeoutHit;
      errorReg <= timeoutHit; // Nobody claimed the instruction number
    end
  end

  always_ff @(posedge s_systemClock) begin
    resultReg <= merged.result; // Zero on a timeout since no unit answered
  end

  assign response.done = doneReg;
  assign response.error = errorReg;
  assign response.result = resultReg;

endmodule

/* ciSubsystem.sv */
`timescale 1ns/1ps

module ciSubsystem import ciPkg::*; (
  input  logic       s_systemClock,
  input  logic       s_pllLocked,
  input  ciRequestT  request,
  output ciResponseT response,
  output logic       ready
);

  ciUnitResponseT swapResponse;
  ciUnitResponseT grayResponse;

  resetCounter resetCounter_i (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .ready(ready)
  );

  byteSwapIse byteSwap_i (
    .s_systemClock(s_systemClock),
    .ready(ready),
    .request(request),
    .unitResponse(swapResponse)
  );

  grayscaleIse grayscale_i (
    .s_systemClock(s_systemClock),
    .ready(ready),
    .request(request),
    .unitResponse(grayResponse)
  );

  ciCombiner combiner_i (
    .s_systemClock(s_systemClock),
    .ready(ready),
    .start(request.start),
    .swapResponse(swapResponse),
    .grayResponse(grayResponse),
    .response(response)
  );

endmodule

/* tbClockGen.sv */
`timescale 1ns/1ps

module tbClockGen (
  output logic s_systemClock
);

  localparam int HalfPeriodNs = 4; // 8 ns clock period

  initial begin
    s_systemClock = 1'b0;
    forever begin
      #HalfPeriodNs s_systemClock = ~s_systemClock;
    end
  end

endmodule

/* ciSubsystemTb.sv */
`timescale 1ns/1ps

module ciSubsystemTb import ciPkg::*, pixelPkg::*; ();

  localparam int ResetLowCycles = 16;
  localparam int ReadyDelayCycles = 16;
  localparam int ReadyTimeout = 40;
  localparam int RowTimeout = 20;
  localparam int RandomPairs = 4;

  typedef struct packed {
    ciIdT   id;
    ciDataT dataA;
    ciDataT dataB;
    ciDataT expResult;
    logic   expError;
  } stimRowT;

  logic       s_systemClock;
  logic       s_pllLocked;
  ciRequestT  request;
  ciResponseT response;
  logic       ready;
  integer     seed;
  stimRowT    stimTable[$];

  tbClockGen clockGen_i (
    .s_systemClock(s_systemClock)
  );

  ciSubsystem ciSubsystem_i (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .request(request),
    .response(response),
    .ready(ready)
  );

  task automatic reportFailure(input string message);
    $display("error at %0t: %s", $time, message);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic reportTimeout(input string what);
    $display("Timeout at %0t: %s", $time, what);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic checkResult(input ciDataT actual, input ciDataT expected, input string what);
    if (actual !== expected) begin
      reportFailure($sformatf("%s result 0x%08h, expected 0x%08h", what, actual, expected));
    end
  endtask

  task automatic checkError(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      reportFailure($sformatf("%s error bit %b, expected %b", what, actual, expected));
    end
  endtask

  task automatic checkLevel(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      reportFailure($sformatf("%s is %b, expected %b", what, actual, expected));
    end
  endtask

  task automatic checkCycles(input int actual, input int expected, input string what);
    if (actual != expected) begin
      reportFailure($sformatf("%s took %0d cycles, expected %0d", what, actual, expected));
    end
  endtask

  function automatic ciDataT swapExpected(input ciDataT word, input ciDataT mode);
    ciDataT swapped;
    for (int i = 0; i < 4; i++) begin
      if (mode[0]) begin
        swapped[8*(i^1) +: 8] = word[8*i +: 8]; // Neighbour byte in the same half-word
      end else begin
        swapped[8*(3-i) +: 8] = word[8*i +: 8]; // Mirror position across the word
      end
    end
    return swapped;
  endfunction

  function automatic ciDataT grayExpected(input ciDataT pixelWord);
    int red;
    int green;
    int blue;
    int sum;
    red = int'(pixelWord[15:11]);
    green = int'(pixelWord[10:5]);
    blue = int'(pixelWord[4:0]);
    red = (red << 3) | (red >> 2);
    green = (green << 2) | (green >> 4);
    blue = (blue << 3) | (blue >> 2);
    sum = int'(RedWeight) * red + int'(GreenWeight) * green + int'(BlueWeight) * blue;
    return ciDataT'(sum >> 8);
  endfunction

  function automatic int expectedLatency(input ciIdT id);
    if (id == SwapByteId) begin
      return 2;
    end else if (id == GrayscaleId) begin
      return 3;
    end else begin
      return CiTimeoutCycles + 1; // Combiner gives up and answers with an error
    end
  endfunction

  task automatic addRow(input ciIdT id, input ciDataT dataA, input ciDataT dataB,
                        input ciDataT expResult, input logic expError);
    stimRowT row;
    row.id = id;
    row.dataA = dataA;
    row.dataB = dataB;
    row.expResult = expResult;
    row.expError = expError;
    stimTable.push_back(row);
  endtask

  task automatic buildTable();
    ciDataT operandA;
    ciDataT operandB;
    addRow(SwapByteId, 32'h11223344, 32'h00000000, 32'h44332211, 1'b0);
    addRow(SwapByteId, 32'hA1B2C3D4, 32'h00000001, 32'hB2A1D4C3, 1'b0);
    addRow(SwapByteId, 32'h0000FF00, 32'hFFFFFFFE, 32'h00FF0000, 1'b0);
    addRow(GrayscaleId, 32'h0000F800, 32'h0, 32'h00000035, 1'b0); // Pure red
    addRow(GrayscaleId, 32'h000007E0, 32'h0, 32'h000000B6, 1'b0); // Pure green
    addRow(GrayscaleId, 32'h0000001F, 32'h0, 32'h00000012, 1'b0); // Pure blue
    addRow(GrayscaleId, 32'h0000FFFF, 32'h0, 32'h000000FF, 1'b0);
    addRow(GrayscaleId, 32'h00000000, 32'h0, 32'h00000000, 1'b0);
    addRow(GrayscaleId, 32'hDEADF800, 32'h0, 32'h00000035, 1'b0); // Upper half is ignored
    addRow(8'd7, 32'h12345678, 32'h1, 32'h00000000, 1'b1);
    addRow(8'd0, 32'hFFFFFFFF, 32'h0, 32'h00000000, 1'b1);
    // Alternating units with random operands
    for (int k = 0; k < RandomPairs; k++) begin
      operandA = $random(seed);
      operandB = $random(seed);
      operandB[0] = k[0];
      addRow(SwapByteId, operandA, operandB, swapExpected(operandA, operandB), 1'b0);
      operandA = $random(seed);
      addRow(GrayscaleId, operandA, 32'h0, grayExpected(operandA), 1'b0);
    end
    addRow(8'hFF, 32'hCAFE0001, 32'h1, 32'h00000000, 1'b1);
  endtask

  task automatic runRow(input stimRowT row, input int index);
    int cycles;
    string label;
    label = $sformatf("row %0d (id 0x%02h)", index, row.id);
    checkLevel(ready, 1'b1, {label, " ready before issue"});
    @(posedge s_systemClock);
    request.start <= 1'b1;
    request.id <= row.id;
    request.dataA <= row.dataA;
    request.dataB <= row.dataB;
    @(posedge s_systemClock);
    request.start <= 1'b0; // One-cycle strobe
    @(negedge s_systemClock);
    cycles = 1;
    while (!response.done) begin
      if (cycles == RowTimeout) begin
        reportTimeout($sformatf("response done did not arrive within %0d cycles for %s",
                                RowTimeout, label));
      end else begin
        @(negedge s_systemClock);
        cycles++;
      end
    end
    checkCycles(cycles, expectedLatency(row.id), label);
    checkResult(response.result, row.expResult, label);
    checkError(response.error, row.expError, label);
  endtask

  initial begin
    int cycles;
    seed = 32'h6d31;
    s_pllLocked <= 1'b0;
    request <= '0;
    buildTable();

    for (int i = 0; i < ResetLowCycles; i++) begin
      @(negedge s_systemClock);
      checkLevel(ready, 1'b0, "ready while PLL unlocked");
      checkLevel(response.done, 1'b0, "response done while PLL unlocked");
    end
    @(posedge s_systemClock);
    s_pllLocked <= 1'b1;
    @(negedge s_systemClock); // Still inside the cycle of the lock edge

    cycles = 0;
    while (!ready) begin
      if (cycles == ReadyTimeout) begin
        reportTimeout("ready never rose after the PLL locked");
      end else begin
        @(negedge s_systemClock);
        cycles++;
        checkLevel(response.done, 1'b0, "response done during reset count");
      end
    end
    checkCycles(cycles, ReadyDelayCycles, "ready rise after PLL lock");

    for (int i = 0; i < stimTable.size(); i++) begin
      runRow(stimTable[i], i);
    end

    // No stray done may follow the last answer
    for (int i = 0; i < CiTimeoutCycles + 2; i++) begin
      @(negedge s_systemClock);
      checkLevel(response.done, 1'b0, "response done after the last row");
    end

    $display("Simulation PASSED");
    $finish;
  end

endmodule

/* sim.f */
ciPkg.sv
pixelPkg.sv
resetCounter.sv
byteSwapIse.sv
grayscaleIse.sv
ciCombiner.sv
ciSubsystem.sv
tbClockGen.sv
ciSubsystemTb.sv

/* run.sh */
#!/bin/sh
# Builds the custom-instruction testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

logFile=sim.log
simBinary=ciSubsystemTbSim

rm -rf obj_dir
if ! verilator --binary --timing --timescale 1ns/1ps -f sim.f \
    --top-module ciSubsystemTb -o "$simBinary"; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/"$simBinary" > "$logFile" 2>&1
runStatus=$?
cat "$logFile"

if grep -q "Simulation FAILED" "$logFile"; then
  echo "Test run reported a failure"
  exit 1
fi

if [ "$runStatus" -ne 0 ]; then
  echo "Simulation exited with status $runStatus"
  exit 1
fi

if ! grep -q "Simulation PASSED" "$logFile"; then
  echo "Simulation ended without a pass report"
  exit 1
fi

exit 0
